// File: source/vga_pkg.sv
`default_nettype none

package vga_pkg;

  // pixel coordinate, wide enough for real monitor timings
  typedef logic [10:0] coord_t;

  // 4 bits per channel, r in the top nibble
  typedef logic [11:0] rgb_t;

  // one pixel of the raster stream, 38 bits
  typedef struct packed {
    coord_t vcount;
    logic   vsync;
    logic   vblnk;
    coord_t hcount;
    logic   hsync;
    logic   hblnk;
    rgb_t   rgb;
  } vga_bus_t;

  // missile position, also used for the enemy shot
  typedef struct packed {
    coord_t x;
    coord_t y;
    logic   on;  // missile in flight
  } missile_t;

endpackage

`default_nettype wire

// File: source/game_pkg.sv
`default_nettype none

package game_pkg;

  // remaining hits before an enemy dies
  typedef logic [1:0] lives_t;

  // game level, saturates at 15
  typedef logic [3:0] level_t;

  // each enemy in the row is either drawn or gone
  typedef enum logic {
    ALIVE,
    DEAD
  } enemy_state_e;

  // level controller
  typedef enum logic {
    PLAY,    // waiting for all enemies to die
    ADVANCE  // one cycle, bump level and revive
  } level_state_e;

  parameter lives_t MAX_LIVES = 2'd3;

endpackage

`default_nettype wire

// File: source/vga_timing.sv
`default_nettype none

module vga_timing
  import vga_pkg::*;
#(
  parameter int   H_ACTIVE = 64,
  parameter int   H_TOTAL  = 80,
  parameter int   V_ACTIVE = 48,
  parameter int   V_TOTAL  = 56,
  parameter rgb_t BG_RGB   = 12'h00f
) (
  input  wire      pclk,
  input  wire      rst_n_i,
  output vga_bus_t bus_o
);

  // syncs sit a few pixels/lines into blanking
  localparam coord_t H_SYNC_START = coord_t'(H_ACTIVE + 4);
  localparam coord_t H_SYNC_END   = coord_t'(H_ACTIVE + 8);
  localparam coord_t V_SYNC_START = coord_t'(V_ACTIVE + 2);
  localparam coord_t V_SYNC_END   = coord_t'(V_ACTIVE + 4);

  coord_t h_nxt;
  coord_t v_nxt;
  logic   hblnk_nxt;
  logic   vblnk_nxt;

  // the bus register itself holds the counters
  always_comb begin
    h_nxt = bus_o.hcount + 1'b1;
    v_nxt = bus_o.vcount;
    if (bus_o.hcount == coord_t'(H_TOTAL - 1)) begin
      h_nxt = '0;
      if (bus_o.vcount == coord_t'(V_TOTAL - 1)) begin
        v_nxt = '0;
      end else begin
        v_nxt = bus_o.vcount + 1'b1;
      end
    end
  end

  assign hblnk_nxt = (h_nxt >= coord_t'(H_ACTIVE));
  assign vblnk_nxt = (v_nxt >= coord_t'(V_ACTIVE));

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bus_o <= '0;
    end else begin
      bus_o.hcount <= h_nxt;
      bus_o.vcount <= v_nxt;
      bus_o.hblnk  <= hblnk_nxt;
      bus_o.vblnk  <= vblnk_nxt;
      bus_o.hsync  <= (h_nxt >= H_SYNC_START) && (h_nxt < H_SYNC_END);
      bus_o.vsync  <= (v_nxt >= V_SYNC_START) && (v_nxt < V_SYNC_END);
      bus_o.rgb    <= (hblnk_nxt || vblnk_nxt) ? rgb_t'(0) : BG_RGB;  // black in blanking
    end
  end

  a_hcount_range: assert property (@(posedge pclk) disable iff (!rst_n_i)
    bus_o.hcount < coord_t'(H_TOTAL));

endmodule

`default_nettype wire

// File: source/enemy_stage.sv
`default_nettype none

module enemy_stage
  import vga_pkg::*;
  import game_pkg::*;
#(
  parameter int   N             = 1,
  parameter int   ENEMY_W       = 8,
  parameter int   ENEMY_H       = 4,
  parameter int   ENEMY_Y       = 8,
  parameter int   ENEMY_SPACING = 16,
  parameter rgb_t ENEMY_RGB     = 12'hf00
) (
  input  wire      pclk,
  input  wire      rst_n_i,
  input  vga_bus_t bus_i,
  input  missile_t missile_i,
  input  wire      respawn_i,
  output vga_bus_t bus_o,
  output logic     alive_o
);

  // rectangle bounds, upper edges exclusive
  localparam coord_t X_LO = coord_t'(N * ENEMY_SPACING);
  localparam coord_t X_HI = coord_t'(N * ENEMY_SPACING + ENEMY_W);
  localparam coord_t Y_LO = coord_t'(ENEMY_Y);
  localparam coord_t Y_HI = coord_t'(ENEMY_Y + ENEMY_H);

  enemy_state_e state_q;
  lives_t       lives_q;

  logic in_rect;
  logic active;
  logic frame_start;
  logic missile_in;
  logic hit;
  logic paint;

  assign in_rect = (bus_i.hcount >= X_LO) && (bus_i.hcount < X_HI) &&
                   (bus_i.vcount >= Y_LO) && (bus_i.vcount < Y_HI);
  assign active      = !bus_i.hblnk && !bus_i.vblnk;
  assign frame_start = (bus_i.hcount == '0) && (bus_i.vcount == '0);

  assign missile_in = missile_i.on &&
                      (missile_i.x >= X_LO) && (missile_i.x < X_HI) &&
                      (missile_i.y >= Y_LO) && (missile_i.y < Y_HI);

  // one hit test per frame
  assign hit   = frame_start && (state_q == ALIVE) && missile_in;
  assign paint = (state_q == ALIVE) && in_rect && active;

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ALIVE;
      lives_q <= MAX_LIVES;
    end else if (respawn_i) begin
      state_q <= ALIVE;
      lives_q <= MAX_LIVES;
    end else if (hit) begin
      lives_q <= lives_q - 1'b1;
      if (lives_q == lives_t'(1)) begin
        state_q <= DEAD;  // last life gone
      end
    end
  end

  // pipeline stage, overlay on top of the incoming colour
  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bus_o <= '0;
    end else begin
      bus_o     <= bus_i;
      bus_o.rgb <= paint ? ENEMY_RGB : bus_i.rgb;
    end
  end

  assign alive_o = (state_q == ALIVE);

  a_lives_dead: assert property (@(posedge pclk) disable iff (!rst_n_i)
    (lives_q == '0) == (state_q == DEAD));

  a_sync_pass: assert property (@(posedge pclk) disable iff (!rst_n_i)
    1'b1 |=> {bus_o.hsync, bus_o.vsync, bus_o.hblnk, bus_o.vblnk} ==
             $past({bus_i.hsync, bus_i.vsync, bus_i.hblnk, bus_i.vblnk}));

endmodule

`default_nettype wire

// File: source/enemy_missile.sv
`default_nettype none

module enemy_missile
  import vga_pkg::*;
  import game_pkg::*;
#(
  parameter int ENEMY_SPACING = 16,
  parameter int ENEMY_W       = 8,
  parameter int ENEMY_Y       = 8,
  parameter int ENEMY_H       = 4,
  parameter int V_ACTIVE      = 48
) (
  input  wire      pclk,
  input  wire      rst_n_i,
  input  vga_bus_t bus_i,
  input  wire      shooter_alive_i,
  input  level_t   level_i,
  output missile_t missile_o
);

  // fired from the centre of enemy 1's bottom edge
  localparam coord_t LAUNCH_X = coord_t'(ENEMY_SPACING + ENEMY_W / 2);
  localparam coord_t LAUNCH_Y = coord_t'(ENEMY_Y + ENEMY_H);

  logic   frame_start;
  coord_t y_nxt;

  assign frame_start = (bus_i.hcount == '0) && (bus_i.vcount == '0);
  assign y_nxt       = missile_o.y + coord_t'(level_i) + 1'b1;  // faster each level

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      missile_o <= '0;
    end else if (frame_start) begin
      if (!missile_o.on) begin
        if (shooter_alive_i) begin
          missile_o <= '{x: LAUNCH_X, y: LAUNCH_Y, on: 1'b1};
        end
      end else if (y_nxt >= coord_t'(V_ACTIVE)) begin
        missile_o.on <= 1'b0;  // left the screen
      end else begin
        missile_o.y <= y_nxt;
      end
    end
  end

  a_on_screen: assert property (@(posedge pclk) disable iff (!rst_n_i)
    missile_o.on |-> missile_o.y < coord_t'(V_ACTIVE));

endmodule

`default_nettype wire

// File: source/level_ctrl.sv
`default_nettype none

module level_ctrl
  import game_pkg::*;
(
  input  wire        pclk,
  input  wire        rst_n_i,
  input  wire  [2:0] alive_i,
  output level_t     level_o,
  output logic       respawn_o
);

  level_state_e state_q;
  level_state_e state_d;
  level_t       level_q;
  level_t       level_d;

  always_comb begin
    state_d = state_q;
    level_d = level_q;
    case (state_q)
      PLAY: begin
        if (alive_i == 3'b000) begin
          state_d = ADVANCE;
        end
      end
      ADVANCE: begin
        state_d = PLAY;
        if (level_q != '1) begin
          level_d = level_q + 1'b1;  // holds at 15
        end
      end
      default: state_d = PLAY;
    endcase
  end

  always_ff @(posedge pclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= PLAY;
      level_q <= '0;
    end else begin
      state_q <= state_d;
      level_q <= level_d;
    end
  end

  // stages revive on this edge, so PLAY sees them alive again
  assign respawn_o = (state_q == ADVANCE);
  assign level_o   = level_q;

  a_single_respawn: assert property (@(posedge pclk) disable iff (!rst_n_i)
    respawn_o |=> !respawn_o);

endmodule

`default_nettype wire

// File: source/enemies.sv
`default_nettype none

module enemies
  import vga_pkg::*;
  import game_pkg::*;
#(
  parameter int   H_ACTIVE      = 64,
  parameter int   H_TOTAL       = 80,
  parameter int   V_ACTIVE      = 48,
  parameter int   V_TOTAL       = 56,
  parameter int   ENEMY_W       = 8,
  parameter int   ENEMY_H       = 4,
  parameter int   ENEMY_Y       = 8,
  parameter int   ENEMY_SPACING = 16,
  parameter rgb_t ENEMY_RGB     = 12'hf00,
  parameter rgb_t BG_RGB        = 12'h00f
) (
  input  wire      pclk,
  input  wire      rst_n_i,
  input  missile_t missile_i,
  output vga_bus_t vga_o,
  output missile_t en1_missile_o,
  output level_t   level_o
);

  vga_bus_t   bus [0:3];  // bus[0] from timing, bus[3] is the output
  logic [2:0] alive;
  logic       respawn;

  vga_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_TOTAL  (H_TOTAL),
    .V_ACTIVE (V_ACTIVE),
    .V_TOTAL  (V_TOTAL),
    .BG_RGB   (BG_RGB)
  ) timing_i (
    .pclk    (pclk),
    .rst_n_i (rst_n_i),
    .bus_o   (bus[0])
  );

  // enemies 1 to 3, left to right
  for (genvar i = 0; i < 3; i++) begin : g_stage
    enemy_stage #(
      .N             (i + 1),
      .ENEMY_W       (ENEMY_W),
      .ENEMY_H       (ENEMY_H),
      .ENEMY_Y       (ENEMY_Y),
      .ENEMY_SPACING (ENEMY_SPACING),
      .ENEMY_RGB     (ENEMY_RGB)
    ) stage_i (
      .pclk      (pclk),
      .rst_n_i   (rst_n_i),
      .bus_i     (bus[i]),
      .missile_i (missile_i),
      .respawn_i (respawn),
      .bus_o     (bus[i+1]),
      .alive_o   (alive[i])
    );
  end

  enemy_missile #(
    .ENEMY_SPACING (ENEMY_SPACING),
    .ENEMY_W       (ENEMY_W),
    .ENEMY_Y       (ENEMY_Y),
    .ENEMY_H       (ENEMY_H),
    .V_ACTIVE      (V_ACTIVE)
  ) missile_i0 (
    .pclk            (pclk),
    .rst_n_i         (rst_n_i),
    .bus_i           (bus[0]),
    .shooter_alive_i (alive[0]),  // only enemy 1 fires
    .level_i         (level_o),
    .missile_o       (en1_missile_o)
  );

  level_ctrl level_i0 (
    .pclk      (pclk),
    .rst_n_i   (rst_n_i),
    .alive_i   (alive),
    .level_o   (level_o),
    .respawn_o (respawn)
  );

  assign vga_o = bus[3];

endmodule

`default_nettype wire

// File: sim/enemies_tb.sv
`default_nettype none

module enemies_tb
  import vga_pkg::*;
  import game_pkg::*;
();

  localparam int   H_ACTIVE      = 64;
  localparam int   H_TOTAL       = 80;
  localparam int   V_ACTIVE      = 48;
  localparam int   V_TOTAL       = 56;
  localparam int   ENEMY_SPACING = 16;
  localparam int   ENEMY_W       = 8;
  localparam int   ENEMY_Y       = 8;
  localparam int   ENEMY_H       = 4;
  localparam rgb_t ENEMY_RGB     = 12'hf80;
  localparam rgb_t BG_RGB        = 12'h014;
  localparam int   FRAME_CYCLES  = H_TOTAL * V_TOTAL;
  localparam coord_t CENTRE_Y    = coord_t'(ENEMY_Y + ENEMY_H / 2);

  // one table row is held for reps frames
  typedef struct packed {
    coord_t     x;
    coord_t     y;
    logic       on;
    logic       rnd;    // random miss instead of x,y
    logic [7:0] reps;
    logic [2:0] alive;  // bit 0 is enemy 1, after the last frame
    level_t     level;
  } row_t;

  localparam int NROWS = 7;

  row_t rows [NROWS] = '{
    '{11'd0,  11'd0,  1'b0, 1'b0, 8'd1, 3'b111, 4'd0},  // first frame, nothing flying
    '{11'd36, 11'd10, 1'b1, 1'b0, 8'd2, 3'b111, 4'd0},  // two hits on enemy 2
    '{11'd36, 11'd10, 1'b0, 1'b0, 8'd1, 3'b111, 4'd0},  // same spot but on low
    '{11'd36, 11'd10, 1'b1, 1'b0, 8'd1, 3'b101, 4'd0},  // last life of enemy 2
    '{11'd0,  11'd0,  1'b1, 1'b1, 8'd6, 3'b101, 4'd0},
    '{11'd20, 11'd10, 1'b1, 1'b0, 8'd3, 3'b100, 4'd0},
    '{11'd52, 11'd10, 1'b1, 1'b0, 8'd3, 3'b111, 4'd1}   // all dead, level up
  };

  logic     pclk;
  logic     rst_n_i;
  missile_t missile_i;
  vga_bus_t vga_o;
  missile_t en1_missile_o;
  level_t   level_o;

  int unsigned lcg_state = 32'hb1fa;

  // reference model state
  int       lives_m [1:3];
  int       level_m;
  missile_t m_exp;

  enemies #(
    .H_ACTIVE      (H_ACTIVE),
    .H_TOTAL       (H_TOTAL),
    .V_ACTIVE      (V_ACTIVE),
    .V_TOTAL       (V_TOTAL),
    .ENEMY_W       (ENEMY_W),
    .ENEMY_H       (ENEMY_H),
    .ENEMY_Y       (ENEMY_Y),
    .ENEMY_SPACING (ENEMY_SPACING),
    .ENEMY_RGB     (ENEMY_RGB),
    .BG_RGB        (BG_RGB)
  ) dut_i (
    .pclk          (pclk),
    .rst_n_i       (rst_n_i),
    .missile_i     (missile_i),
    .vga_o         (vga_o),
    .en1_missile_o (en1_missile_o),
    .level_o       (level_o)
  );

  always #10 pclk = ~pclk;

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_rgb(input rgb_t got, input rgb_t want, input string what);
    if (got !== want)
      abort_run($sformatf("Fail %0t: %s rgb %h, expected %h", $time, what, got, want));
  endtask

  task automatic check_sync(input vga_bus_t got, input vga_bus_t want, input string what);
    if ({got.hsync, got.hblnk, got.vsync, got.vblnk} !==
        {want.hsync, want.hblnk, want.vsync, want.vblnk})
      abort_run($sformatf("Fail %0t: %s hsync,hblnk,vsync,vblnk %b%b%b%b, expected %b%b%b%b",
                          $time, what, got.hsync, got.hblnk, got.vsync, got.vblnk,
                          want.hsync, want.hblnk, want.vsync, want.vblnk));
  endtask

  task automatic check_level(input level_t got, input level_t want, input string what);
    if (got !== want)
      abort_run($sformatf("Fail %0t: %s level %0d, expected %0d", $time, what, got, want));
  endtask

  task automatic check_missile(input missile_t got, input missile_t want, input string what);
    if (got !== want)
      abort_run($sformatf("Fail %0t: %s at %0d,%0d on %b, expected %0d,%0d on %b", $time,
                          what, got.x, got.y, got.on, want.x, want.y, want.on));
  endtask

  // samples on the falling edge, vga_o is stable there
  task automatic wait_pixel(input coord_t x, input coord_t y);
    int count;
    count = 0;
    do begin
      @(negedge pclk);
      count++;
      if (count > FRAME_CYCLES + 8)
        abort_run($sformatf("timed out waiting for pixel %0d,%0d on vga_o", x, y));
    end while (vga_o.hcount != x || vga_o.vcount != y);
  endtask

  // blank outside active, syncs 4..8 pixels and 2..4 lines after active
  function automatic vga_bus_t raster_flags(input coord_t x, input coord_t y);
    vga_bus_t b;
    b        = '0;
    b.hcount = x;
    b.vcount = y;
    b.hblnk  = (x >= H_ACTIVE);
    b.vblnk  = (y >= V_ACTIVE);
    b.hsync  = (x >= H_ACTIVE + 4) && (x < H_ACTIVE + 8);
    b.vsync  = (y >= V_ACTIVE + 2) && (y < V_ACTIVE + 4);
    return b;
  endfunction

  task automatic probe_pixel(input coord_t x, input coord_t y, input rgb_t want,
                             input string what);
    wait_pixel(x, y);
    check_sync(vga_o, raster_flags(x, y), what);
    check_rgb(vga_o.rgb, want, what);
  endtask

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic in_enemy(input int n, input missile_t m);
    return int'(m.x) >= n * ENEMY_SPACING && int'(m.x) < n * ENEMY_SPACING + ENEMY_W &&
           int'(m.y) >= ENEMY_Y && int'(m.y) < ENEMY_Y + ENEMY_H;
  endfunction

  function automatic missile_t random_miss();
    missile_t m;
    m.on = 1'b1;
    do begin
      m.x = coord_t'((lcg_next() >> 8) % H_ACTIVE);
      m.y = coord_t'((lcg_next() >> 8) % V_ACTIVE);
    end while (in_enemy(1, m) || in_enemy(2, m) || in_enemy(3, m));
    return m;
  endfunction

  function automatic level_t sat_level(input int v);
    return level_t'((v > 15) ? 15 : v);
  endfunction

  function automatic logic [2:0] model_mask();
    return {lives_m[3] > 0, lives_m[2] > 0, lives_m[1] > 0};
  endfunction

  // missile moves with last frame's level and shooter, then hits, then respawn
  task automatic model_frame(input missile_t shot);
    int ny;
    ny = int'(m_exp.y) + level_m + 1;
    if (!m_exp.on) begin
      if (lives_m[1] > 0)
        m_exp = '{x: coord_t'(ENEMY_SPACING + ENEMY_W / 2),
                  y: coord_t'(ENEMY_Y + ENEMY_H), on: 1'b1};
    end else if (ny >= V_ACTIVE) begin
      m_exp.on = 1'b0;
    end else begin
      m_exp.y = coord_t'(ny);
    end
    for (int n = 1; n <= 3; n++) begin
      if (lives_m[n] > 0 && shot.on && in_enemy(n, shot))
        lives_m[n]--;
    end
    if (model_mask() == 3'b000) begin
      level_m = int'(sat_level(level_m + 1));
      for (int n = 1; n <= 3; n++)
        lives_m[n] = 3;
    end
  endtask

  task automatic scan_frame();
    rgb_t want;
    for (int n = 1; n <= 3; n++) begin
      want = (lives_m[n] > 0) ? ENEMY_RGB : BG_RGB;
      probe_pixel(coord_t'(n * ENEMY_SPACING + ENEMY_W / 2), CENTRE_Y, want,
                  $sformatf("enemy %0d centre", n));
      if (n == 1) begin
        check_level(level_o, level_t'(level_m), "level during frame");
        probe_pixel(coord_t'(ENEMY_SPACING + ENEMY_W + 4), CENTRE_Y, BG_RGB,
                    "gap between enemies");  // gap before enemy 2
      end
    end
    probe_pixel(coord_t'(H_ACTIVE + 6), CENTRE_Y, rgb_t'(0), "horizontal blanking");
    probe_pixel(coord_t'(10), coord_t'(V_ACTIVE + 2), rgb_t'(0), "vertical blanking");
  endtask

  // called on a falling edge, the shot is tested at the next frame start
  task automatic apply_row(input row_t r, input string name);
    missile_t shot;
    for (int k = 0; k < int'(r.reps); k++) begin
      shot = r.rnd ? random_miss() : missile_t'{x: r.x, y: r.y, on: r.on};
      missile_i = shot;
      wait_pixel(coord_t'(1), coord_t'(0));  // hit tests of this frame are done
      model_frame(shot);
      check_missile(en1_missile_o, m_exp, "enemy missile");
      scan_frame();
    end
    check_level(level_o, r.level, {name, " end"});
    if (model_mask() != r.alive)
      abort_run($sformatf("%s expects alive mask %b but the model predicts %b",
                          name, r.alive, model_mask()));
  endtask

  initial begin
    row_t round_row;
    pclk      = 1'b0;
    rst_n_i   = 1'b0;
    missile_i = '0;  // stays off in frame 0, stages 2 and 3 see extra frame starts
    m_exp     = '0;
    level_m   = 0;
    for (int n = 1; n <= 3; n++)
      lives_m[n] = 3;
    repeat (3) @(negedge pclk);
    rst_n_i = 1'b1;

    for (int i = 0; i < NROWS; i++)
      apply_row(rows[i], $sformatf("table row %0d", i));

    // kill rounds up to and past level 15
    for (int round = 2; round <= 17; round++) begin
      for (int n = 1; n <= 3; n++) begin
        round_row.x     = coord_t'(n * ENEMY_SPACING + ENEMY_W / 2);
        round_row.y     = CENTRE_Y;
        round_row.on    = 1'b1;
        round_row.rnd   = 1'b0;
        round_row.reps  = 8'd3;
        round_row.alive = (n == 3) ? 3'b111 : (3'b111 << n);
        round_row.level = (n == 3) ? sat_level(round) : sat_level(round - 1);
        apply_row(round_row, $sformatf("round %0d enemy %0d", round, n));
      end
    end

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
source/vga_pkg.sv
source/game_pkg.sv
source/vga_timing.sv
source/enemy_stage.sv
source/enemy_missile.sv
source/level_ctrl.sv
source/enemies.sv
sim/enemies_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f compile.f --top-module enemies_tb -o enemies_sim; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/enemies_sim 2>&1)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
  exit 0
fi
exit 1
